// ==== logic/axi_lite_pkg.sv ====
/*
 * AXI-Lite bus definitions shared by the slave front end and the top level.
 * Data and address widths, response codes, the master request struct,
 * the slave response struct and the slave FSM state type.
 */

`default_nettype none

package axi_lite_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // Response codes on B and R
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // Slave FSM, one transaction in flight at a time
    typedef enum logic [1:0] {
        idle       = 2'd0,
        write_data = 2'd1,
        write_resp = 2'd2,
        read_resp  = 2'd3
    } axi_slave_state_e;

    // Everything the master drives
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  awvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic [AXI_STRB_W-1:0] wstrb;
        logic                  wvalid;
        logic                  bready;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
    } axi_lite_req_t;

    // Everything the slave drives
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        axi_resp_e             bresp;
        logic                  bvalid;
        logic                  arready;
        logic [AXI_DATA_W-1:0] rdata;
        axi_resp_e             rresp;
        logic                  rvalid;
    } axi_lite_rsp_t;

endpackage

`default_nettype wire

// ==== logic/clint_pkg.sv ====
/*
 * Interrupt controller definitions.
 * Register map, register widths, reset values, the default mtime tick
 * divider and the register access request and response structs.
 */

`default_nettype none

package clint_pkg;

    localparam int REG_ADDR_W = 32;
    localparam int REG_DATA_W = 32;
    localparam int REG_STRB_W = REG_DATA_W / 8;
    localparam int MTIME_W    = 64;

    // Register map, single hart, word aligned
    localparam logic [REG_ADDR_W-1:0] MSIP_ADDR        = 32'h0000_0000;
    localparam logic [REG_ADDR_W-1:0] MTIMECMP_LO_ADDR = 32'h0000_4000;
    localparam logic [REG_ADDR_W-1:0] MTIMECMP_HI_ADDR = 32'h0000_4004;
    localparam logic [REG_ADDR_W-1:0] MTIME_LO_ADDR    = 32'h0000_BFF8;
    localparam logic [REG_ADDR_W-1:0] MTIME_HI_ADDR    = 32'h0000_BFFC;

    // Compare at max so the timer interrupt stays quiet after reset
    localparam logic [MTIME_W-1:0] MTIMECMP_RESET = {MTIME_W{1'b1}};

    // Clock cycles per mtime increment
    localparam int MTIME_DIV_DEFAULT = 4;

    // Single-cycle register strobe from the bus slave
    typedef struct packed {
        logic                  wr_en;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] wdata;
        logic [REG_STRB_W-1:0] wstrb;
    } reg_req_t;

    // Combinational answer for the current address
    typedef struct packed {
        logic [REG_DATA_W-1:0] rdata;
        logic                  err;
    } reg_rsp_t;

endpackage

`default_nettype wire

// ==== logic/axi_lite_slave_ctrl.sv ====
/*
 * AXI-Lite slave front end.
 * Four-state FSM that accepts one write or one read at a time, turns the
 * W handshake into a single-cycle register write strobe and registers the
 * read data and the B/R responses until the master takes them.
 */

`timescale 1ns/100ps
`default_nettype none

module axi_lite_slave_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axi_lite_pkg::axi_lite_req_t bus_req,
    output axi_lite_pkg::axi_lite_rsp_t bus_rsp,
    output clint_pkg::reg_req_t         reg_req,
    input  clint_pkg::reg_rsp_t         reg_rsp
);

    import axi_lite_pkg::*;

    axi_slave_state_e      state;
    logic [AXI_ADDR_W-1:0] awaddr_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    axi_resp_e             rresp_q;
    axi_resp_e             bresp_q;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;

    // Write address wins over a read address arriving in the same cycle
    assign aw_hs = (state == idle) && bus_req.awvalid;
    assign ar_hs = (state == idle) && bus_req.arvalid && !bus_req.awvalid;
    assign w_hs  = (state == write_data) && bus_req.wvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (aw_hs) begin
                        state <= write_data;
                    end else if (ar_hs) begin
                        state <= read_resp;
                    end
                end
                write_data: begin
                    if (w_hs) begin
                        state <= write_resp;
                    end
                end
                write_resp: begin
                    if (bus_req.bready) begin
                        state <= idle;
                    end
                end
                read_resp: begin
                    if (bus_req.rready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Captured address, read data and responses
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awaddr_q <= bus_req.awaddr;
        end
        if (ar_hs) begin
            rdata_q <= reg_rsp.rdata;
            rresp_q <= reg_rsp.err ? SLVERR : OKAY;
        end
        if (w_hs) begin
            bresp_q <= reg_rsp.err ? SLVERR : OKAY;
        end
    end

    // Read address goes straight to the registers while idle
    assign reg_req.wr_en = w_hs;
    assign reg_req.addr  = (state == write_data) ? awaddr_q : bus_req.araddr;
    assign reg_req.wdata = bus_req.wdata;
    assign reg_req.wstrb = bus_req.wstrb;

    assign bus_rsp.awready = (state == idle);
    assign bus_rsp.arready = (state == idle) && !bus_req.awvalid;
    assign bus_rsp.wready  = (state == write_data);
    assign bus_rsp.bvalid  = (state == write_resp);
    assign bus_rsp.bresp   = bresp_q;
    assign bus_rsp.rvalid  = (state == read_resp);
    assign bus_rsp.rdata   = rdata_q;
    assign bus_rsp.rresp   = rresp_q;

    // Write response held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid && $stable(bus_rsp.bresp))
    else $error("write response changed while stalled");

    // Read payload held under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.rvalid && !bus_req.rready |=>
            bus_rsp.rvalid && $stable(bus_rsp.rdata) && $stable(bus_rsp.rresp))
    else $error("read response changed while stalled");

endmodule

`default_nettype wire

// ==== logic/clint_regs.sv ====
/*
 * Interrupt controller register block.
 * msip and the two mtimecmp halves, address decode, byte-strobe merge on
 * writes, read-data selection including mtime, and error flagging for
 * unmapped addresses and for writes to the read-only mtime.
 */

`timescale 1ns/100ps
`default_nettype none

module clint_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  clint_pkg::reg_req_t             reg_req,
    output clint_pkg::reg_rsp_t             reg_rsp,
    input  logic [clint_pkg::MTIME_W-1:0]   mtime,
    output logic [clint_pkg::MTIME_W-1:0]   mtimecmp,
    output logic                            soft_irq
);

    import clint_pkg::*;

    logic                 msip_q;
    logic [MTIME_W-1:0]   mtimecmp_q;

    logic sel_msip;
    logic sel_cmp_lo;
    logic sel_cmp_hi;
    logic sel_mtime;
    logic mapped;
    logic wr_ok;

    // Replace only the bytes enabled in the strobe
    function automatic logic [REG_DATA_W-1:0] merge_bytes(
        input logic [REG_DATA_W-1:0] old_val,
        input logic [REG_DATA_W-1:0] new_val,
        input logic [REG_STRB_W-1:0] strb
    );
        logic [REG_DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < REG_STRB_W; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign sel_msip   = (reg_req.addr == MSIP_ADDR);
    assign sel_cmp_lo = (reg_req.addr == MTIMECMP_LO_ADDR);
    assign sel_cmp_hi = (reg_req.addr == MTIMECMP_HI_ADDR);
    assign sel_mtime  = (reg_req.addr == MTIME_LO_ADDR) || (reg_req.addr == MTIME_HI_ADDR);
    assign mapped     = sel_msip || sel_cmp_lo || sel_cmp_hi || sel_mtime;

    // mtime is read only, so writing it is an error like an unmapped access
    assign reg_rsp.err = !mapped || (reg_req.wr_en && sel_mtime);
    assign wr_ok       = reg_req.wr_en && !reg_rsp.err;

    always_comb begin
        case (reg_req.addr)
            MSIP_ADDR:        reg_rsp.rdata = {{(REG_DATA_W-1){1'b0}}, msip_q};
            MTIMECMP_LO_ADDR: reg_rsp.rdata = mtimecmp_q[31:0];
            MTIMECMP_HI_ADDR: reg_rsp.rdata = mtimecmp_q[63:32];
            MTIME_LO_ADDR:    reg_rsp.rdata = mtime[31:0];
            MTIME_HI_ADDR:    reg_rsp.rdata = mtime[63:32];
            // Easy to spot on the bus
            default:          reg_rsp.rdata = {REG_DATA_W{1'b1}};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msip_q     <= 1'b0;
            mtimecmp_q <= MTIMECMP_RESET;
        end else if (wr_ok) begin
            // Only bit 0 of msip exists, it sits in byte lane 0
            if (sel_msip && reg_req.wstrb[0]) begin
                msip_q <= reg_req.wdata[0];
            end
            if (sel_cmp_lo) begin
                mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], reg_req.wdata, reg_req.wstrb);
            end
            if (sel_cmp_hi) begin
                mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], reg_req.wdata, reg_req.wstrb);
            end
        end
    end

    assign mtimecmp = mtimecmp_q;
    assign soft_irq = msip_q;

    // A rejected mtime write must not leak into any register
    assert property (@(posedge clk) disable iff (!rst_n)
        reg_req.wr_en && sel_mtime |=> $stable(msip_q) && $stable(mtimecmp_q))
    else $error("write to mtime changed a register");

endmodule

`default_nettype wire

// ==== logic/mtime_timer.sv ====
/*
 * Machine timer.
 * Tick prescaler, free-running 64-bit mtime counter and the
 * mtime >= mtimecmp compare that drives the timer interrupt.
 */

`timescale 1ns/100ps
`default_nettype none

module mtime_timer #(
    parameter int MTIME_DIV = clint_pkg::MTIME_DIV_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [clint_pkg::MTIME_W-1:0] mtimecmp,
    output logic [clint_pkg::MTIME_W-1:0] mtime,
    output logic                          timer_irq
);

    // Wide enough to hold MTIME_DIV - 1 for any divider of 1 or more
    logic [$clog2(MTIME_DIV+1)-1:0] div_cnt;
    logic [clint_pkg::MTIME_W-1:0]  mtime_q;
    logic                           tick;

    assign tick = (div_cnt == $bits(div_cnt)'(MTIME_DIV - 1));

    // Prescaler
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else if (tick) begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    assign mtime     = mtime_q;
    assign timer_irq = (mtime_q >= mtimecmp);

    // Counter only moves forward
    assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> mtime_q >= $past(mtime_q))
    else $error("mtime went backwards");

endmodule

`default_nettype wire

// ==== logic/clint_top.sv ====
/*
 * Interrupt controller top level.
 * Connects the AXI-Lite slave front end, the register block and the
 * machine timer, and exposes the timer and software interrupts.
 */

`timescale 1ns/100ps
`default_nettype none

module clint_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  axi_lite_pkg::axi_lite_req_t bus_req,
    output axi_lite_pkg::axi_lite_rsp_t bus_rsp,
    output logic                        timer_irq,
    output logic                        soft_irq
);

    import clint_pkg::*;

    reg_req_t           reg_req;
    reg_rsp_t           reg_rsp;
    logic [MTIME_W-1:0] mtime;
    logic [MTIME_W-1:0] mtimecmp;

    axi_lite_slave_ctrl i_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .reg_req (reg_req),
        .reg_rsp (reg_rsp)
    );

    clint_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .soft_irq (soft_irq)
    );

    mtime_timer #(
        .MTIME_DIV (MTIME_DIV_DEFAULT)
    ) i_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .mtimecmp  (mtimecmp),
        .mtime     (mtime),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

// ==== testbench/clint_tb.sv ====
/*
 * Testbench for the interrupt controller top level.
 * AXI-Lite master tasks with random ready delays, a table of register
 * accesses with expected responses and interrupt levels, timer interrupt
 * sequence and simultaneous write/read requests.
 */

`timescale 1ns/100ps
`default_nettype none

module clint_tb;

    import axi_lite_pkg::*;
    import clint_pkg::*;

    localparam int          CLK_PERIOD     = 10;
    localparam int          DRIVE_DLY      = 1;
    localparam int          WAIT_LIMIT     = 50;
    localparam int          IRQ_WAIT_LIMIT = 400;
    localparam int          MAX_READY_DLY  = 3;
    localparam int          OP_WR          = 0;
    localparam int          OP_RD          = 1;
    localparam int          IRQ_LO         = 0;
    localparam int          IRQ_HI         = 1;
    localparam int          IRQ_X          = 2;
    localparam logic [31:0] ALL            = 32'hFFFF_FFFF;
    localparam logic [31:0] NONE           = 32'h0;
    localparam int          CH_AW          = 0;
    localparam int          CH_W           = 1;
    localparam int          CH_B           = 2;
    localparam int          CH_AR          = 3;
    localparam int          CH_R           = 4;

    typedef struct packed {
        int          op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        axi_resp_e   resp;
        logic [31:0] rdata;
        logic [31:0] mask;
        int          timer_exp;
        int          soft_exp;
    } step_t;

    logic          clk;
    logic          rst_n;
    axi_lite_req_t bus_req;
    axi_lite_rsp_t bus_rsp;
    logic          timer_irq;
    logic          soft_irq;

    integer seed = 28;
    int     err_cnt = 0;
    int     chk_cnt = 0;
    step_t  stim_q[$];

    clint_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic step_to_drive();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    function automatic int random_delay();
        return $unsigned($random(seed)) % (MAX_READY_DLY + 1);
    endfunction

    // Expected register value after a write under byte strobes
    function automatic logic [31:0] merge_lanes(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic abort_on_timeout(input string what);
        err_cnt++;
        $display("timeout at %0d ns: %s never happened", $time, what);
        $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp,
        input logic [31:0] mask
    );
        chk_cnt++;
        assert ((got & mask) === (exp & mask)) else begin
            err_cnt++;
            $display("mismatch at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        chk_cnt++;
        assert (cond === 1'b1) else begin
            err_cnt++;
            $display("error at %0d ns: %s", $time, what);
        end
    endtask

    // Slave side of each handshake
    function automatic logic channel_ready(input int ch);
        case (ch)
            CH_AW:   return bus_rsp.awready;
            CH_W:    return bus_rsp.wready;
            CH_B:    return bus_rsp.bvalid;
            CH_AR:   return bus_rsp.arready;
            default: return bus_rsp.rvalid;
        endcase
    endfunction

    // Returns at the falling edge before the transfer edge
    task automatic wait_ready(input int ch, input string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!channel_ready(ch)) begin
            if (cnt == WAIT_LIMIT) abort_on_timeout(what);
            cnt++;
            @(negedge clk);
        end
    endtask

    task automatic bus_write(
        input  logic [31:0] addr,
        input  logic [31:0] data,
        input  logic [3:0]  strb,
        output axi_resp_e   resp
    );
        bus_req.awaddr  = addr;
        bus_req.awvalid = 1'b1;
        wait_ready(CH_AW, "write address handshake");
        step_to_drive();
        bus_req.awvalid = 1'b0;
        repeat (random_delay()) step_to_drive();
        bus_req.wdata  = data;
        bus_req.wstrb  = strb;
        bus_req.wvalid = 1'b1;
        wait_ready(CH_W, "write data handshake");
        step_to_drive();
        bus_req.wvalid = 1'b0;
        repeat (random_delay()) step_to_drive();
        bus_req.bready = 1'b1;
        wait_ready(CH_B, "write response");
        resp = bus_rsp.bresp;
        step_to_drive();
        bus_req.bready = 1'b0;
    endtask

    task automatic bus_read(
        input  logic [31:0] addr,
        output logic [31:0] data,
        output axi_resp_e   resp
    );
        bus_req.araddr  = addr;
        bus_req.arvalid = 1'b1;
        wait_ready(CH_AR, "read address handshake");
        step_to_drive();
        bus_req.arvalid = 1'b0;
        repeat (random_delay()) step_to_drive();
        bus_req.rready = 1'b1;
        wait_ready(CH_R, "read response");
        data = bus_rsp.rdata;
        resp = bus_rsp.rresp;
        step_to_drive();
        bus_req.rready = 1'b0;
    endtask

    task automatic add_step(
        input int          op,
        input logic [31:0] addr,
        input logic [31:0] wdata,
        input logic [3:0]  strb,
        input axi_resp_e   resp,
        input logic [31:0] rdata,
        input logic [31:0] mask,
        input int          timer_exp,
        input int          soft_exp
    );
        stim_q.push_back('{op, addr, wdata, strb, resp, rdata, mask, timer_exp, soft_exp});
    endtask

    task automatic build_steps();
        logic [31:0] cmp_lo;
        logic [31:0] cmp_hi;
        // Reset values
        add_step(OP_RD, MSIP_ADDR, 0, 0, OKAY, 32'h0, ALL, IRQ_LO, IRQ_LO);
        add_step(OP_RD, MTIMECMP_LO_ADDR, 0, 0, OKAY, ALL, ALL, IRQ_LO, IRQ_LO);
        add_step(OP_RD, MTIMECMP_HI_ADDR, 0, 0, OKAY, ALL, ALL, IRQ_LO, IRQ_LO);
        // Software interrupt
        add_step(OP_WR, MSIP_ADDR, 32'h1, 4'hF, OKAY, 0, NONE, IRQ_LO, IRQ_HI);
        add_step(OP_RD, MSIP_ADDR, 0, 0, OKAY, 32'h1, ALL, IRQ_LO, IRQ_HI);
        add_step(OP_WR, MSIP_ADDR, 32'h0, 4'hF, OKAY, 0, NONE, IRQ_LO, IRQ_LO);
        add_step(OP_WR, MSIP_ADDR, ALL, 4'hF, OKAY, 0, NONE, IRQ_LO, IRQ_HI);
        add_step(OP_RD, MSIP_ADDR, 0, 0, OKAY, 32'h1, ALL, IRQ_LO, IRQ_HI);
        add_step(OP_WR, MSIP_ADDR, 32'h0, 4'hF, OKAY, 0, NONE, IRQ_LO, IRQ_LO);
        // Partial strobes on mtimecmp
        cmp_lo = merge_lanes(ALL, 32'h11223344, 4'b0001);
        add_step(OP_WR, MTIMECMP_LO_ADDR, 32'h11223344, 4'b0001, OKAY, 0, NONE, IRQ_LO, IRQ_X);
        add_step(OP_RD, MTIMECMP_LO_ADDR, 0, 0, OKAY, cmp_lo, ALL, IRQ_LO, IRQ_X);
        cmp_lo = merge_lanes(cmp_lo, 32'hA5A5A5A5, 4'b1010);
        add_step(OP_WR, MTIMECMP_LO_ADDR, 32'hA5A5A5A5, 4'b1010, OKAY, 0, NONE, IRQ_LO, IRQ_X);
        add_step(OP_RD, MTIMECMP_LO_ADDR, 0, 0, OKAY, cmp_lo, ALL, IRQ_LO, IRQ_X);
        cmp_hi = merge_lanes(ALL, 32'h0BADF00D, 4'b0110);
        add_step(OP_WR, MTIMECMP_HI_ADDR, 32'h0BADF00D, 4'b0110, OKAY, 0, NONE, IRQ_LO, IRQ_X);
        add_step(OP_RD, MTIMECMP_HI_ADDR, 0, 0, OKAY, cmp_hi, ALL, IRQ_LO, IRQ_X);
        // Rejected writes leave every register alone
        add_step(OP_WR, MTIME_LO_ADDR, 32'h0, 4'hF, SLVERR, 0, NONE, IRQ_LO, IRQ_LO);
        add_step(OP_WR, MTIME_HI_ADDR, 32'h0, 4'hF, SLVERR, 0, NONE, IRQ_LO, IRQ_LO);
        add_step(OP_WR, 32'h0000_4008, 32'h1, 4'hF, SLVERR, 0, NONE, IRQ_LO, IRQ_LO);
        add_step(OP_WR, 32'h0000_1000, 32'h1, 4'hF, SLVERR, 0, NONE, IRQ_LO, IRQ_LO);
        add_step(OP_RD, MTIMECMP_LO_ADDR, 0, 0, OKAY, cmp_lo, ALL, IRQ_LO, IRQ_LO);
        add_step(OP_RD, MTIMECMP_HI_ADDR, 0, 0, OKAY, cmp_hi, ALL, IRQ_LO, IRQ_LO);
        add_step(OP_RD, MSIP_ADDR, 0, 0, OKAY, 32'h0, ALL, IRQ_LO, IRQ_LO);
        add_step(OP_RD, 32'h0000_2000, 0, 0, SLVERR, 0, NONE, IRQ_LO, IRQ_LO);
        add_step(OP_RD, MTIME_LO_ADDR, 0, 0, OKAY, 0, NONE, IRQ_LO, IRQ_LO);
        add_step(OP_RD, MTIME_HI_ADDR, 0, 0, OKAY, 32'h0, ALL, IRQ_LO, IRQ_LO);
    endtask

    task automatic apply_step(input step_t s, input int idx);
        logic [31:0] rd;
        axi_resp_e   resp;
        if (s.op == OP_WR) begin
            bus_write(s.addr, s.wdata, s.wstrb, resp);
            check_value($sformatf("bresp[%0d]", idx), 32'(resp), 32'(s.resp), ALL);
        end else begin
            bus_read(s.addr, rd, resp);
            check_value($sformatf("rresp[%0d]", idx), 32'(resp), 32'(s.resp), ALL);
            if (s.mask != NONE) check_value($sformatf("rdata[%0d]", idx), rd, s.rdata, s.mask);
        end
        if (s.timer_exp != IRQ_X) begin
            check_value($sformatf("timer_irq[%0d]", idx), 32'(timer_irq), 32'(s.timer_exp), ALL);
        end
        if (s.soft_exp != IRQ_X) begin
            check_value($sformatf("soft_irq[%0d]", idx), 32'(soft_irq), 32'(s.soft_exp), ALL);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] prev;
        logic [31:0] hi;
        logic [63:0] target;
        axi_resp_e   wresp;
        axi_resp_e   rresp;
        time         wr_done;
        time         rd_done;
        int          cnt;
        bus_req = '0;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        check_value("awready", 32'(bus_rsp.awready), 32'h1, ALL);
        check_value("arready", 32'(bus_rsp.arready), 32'h1, ALL);
        check_value("wready", 32'(bus_rsp.wready), 32'h0, ALL);
        check_value("bvalid", 32'(bus_rsp.bvalid), 32'h0, ALL);
        check_value("rvalid", 32'(bus_rsp.rvalid), 32'h0, ALL);

        build_steps();
        for (int i = 0; i < stim_q.size(); i++) begin
            apply_step(stim_q[i], i);
        end

        // mtime keeps counting across reads spaced more than one tick apart
        bus_read(MTIME_LO_ADDR, prev, rresp);
        for (int k = 0; k < 3; k++) begin
            repeat (2 * MTIME_DIV_DEFAULT) step_to_drive();
            bus_read(MTIME_LO_ADDR, rd, rresp);
            check_true(rd > prev, "mtime did not increase between two reads");
            prev = rd;
        end

        // Arm the compare 20 ticks ahead
        bus_read(MTIME_HI_ADDR, hi, rresp);
        bus_read(MTIME_LO_ADDR, rd, rresp);
        target = {hi, rd} + 64'd20;
        bus_write(MTIMECMP_LO_ADDR, target[31:0], 4'hF, wresp);
        bus_write(MTIMECMP_HI_ADDR, target[63:32], 4'hF, wresp);
        check_value("timer_irq armed", 32'(timer_irq), 32'h0, ALL);
        cnt = 0;
        while (!timer_irq) begin
            if (cnt == IRQ_WAIT_LIMIT) abort_on_timeout("timer_irq after mtimecmp write");
            cnt++;
            step_to_drive();
        end
        bus_read(MTIME_LO_ADDR, rd, rresp);
        check_true(rd >= target[31:0], "timer_irq rose before mtime reached mtimecmp");
        bus_write(MTIMECMP_LO_ADDR, ALL, 4'hF, wresp);
        bus_write(MTIMECMP_HI_ADDR, ALL, 4'hF, wresp);
        check_value("timer_irq cleared", 32'(timer_irq), 32'h0, ALL);

        // Write and read raised together and the write goes first
        for (int k = 0; k < 2; k++) begin
            fork
                begin
                    bus_write(k == 0 ? MSIP_ADDR : MTIMECMP_LO_ADDR,
                              k == 0 ? 32'h1 : 32'h12345678, 4'hF, wresp);
                    wr_done = $time;
                end
                begin
                    bus_read(k == 0 ? MSIP_ADDR : MTIMECMP_LO_ADDR, rd, rresp);
                    rd_done = $time;
                end
            join
            check_true(wr_done < rd_done, "read completed before the concurrent write");
            check_value("bresp concurrent", 32'(wresp), 32'(OKAY), ALL);
            check_value("rresp concurrent", 32'(rresp), 32'(OKAY), ALL);
            check_value("rdata concurrent", rd, k == 0 ? 32'h1 : 32'h12345678, ALL);
        end
        check_value("soft_irq concurrent", 32'(soft_irq), 32'h1, ALL);
        check_value("timer_irq concurrent", 32'(timer_irq), 32'h0, ALL);

        $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/axi_lite_pkg.sv
logic/clint_pkg.sv
logic/axi_lite_slave_ctrl.sv
logic/clint_regs.sv
logic/mtime_timer.sv
logic/clint_top.sv
testbench/clint_tb.sv
